// File: hw/bus_panel_config.svh
`ifndef BUS_PANEL_CONFIG_SVH
`define BUS_PANEL_CONFIG_SVH

// bus geometry
`define DATA_WIDTH      16
`define MASTER_COUNT    2
`define SLAVE_COUNT     3
`define ADDR_WIDTH      12
`define SLAVE_ID_WIDTH  2   // zero selects no slave

// slave depths in words
`define SLAVE1_DEPTH    4096
`define SLAVE2_DEPTH    4096
`define SLAVE3_DEPTH    2048

// externally entered values per master
`define BANK_DEPTH      16

// configuration stream and start scheduling
`define SLOT_CYCLES     2
`define START_DELAY     0   // cycles between staggered start pulses
`define FIRST_MASTER    0   // starts first when START_DELAY is not zero

`endif

// File: hw/bus_panel_pkg.sv
`include "bus_panel_config.svh"

package bus_panel_pkg;

    // front panel phases, walked by the step key
    typedef enum logic [3:0] {
        pick_slave,
        pick_rw,
        pick_ext,
        ext_write_m0,
        ext_write_m1,
        ext_write_both,   // fills master 0, then moves on to master 1
        first_addr_m0,
        first_addr_m1,
        count_m0,
        count_m1,
        configure,
        com_ready,
        communicating,
        com_done
    } panel_state_e;

    typedef enum logic [1:0] {
        step_first,
        step_middle,
        step_last,
        step_done
    } config_step_e;

    typedef struct packed {
        logic                         start;
        logic                         eoc;
        logic                         burst;
        logic                         rd_wr;
        logic                         in_ex;
        logic [`SLAVE_ID_WIDTH-1:0]   slave_id;
        logic [`ADDR_WIDTH-1:0]       address;
        logic [`ADDR_WIDTH-1:0]       last_addr;
        logic [`DATA_WIDTH-1:0]       data;
    } master_cmd_t;

    typedef struct packed {
        logic [`SLAVE_ID_WIDTH-1:0]   slave_id;
        logic                         rd_wr;
        logic                         in_ex;
    } master_setup_t;

    typedef struct packed {
        logic idle;
        logic ready;
        logic busy;
        logic done;
    } panel_status_t;

endpackage

// File: hw/panel_fsm.sv
`timescale 1ns/1ps
`include "bus_panel_config.svh"

module panel_fsm (
    input  logic                                              clk,
    input  logic                                              rstN,
    input  logic                                              step_n,
    input  logic [17:0]                                       sw,
    input  logic                                              config_done,
    input  logic [`MASTER_COUNT-1:0]                          done,
    output bus_panel_pkg::panel_state_e                       state,
    output bus_panel_pkg::master_setup_t [`MASTER_COUNT-1:0]  setup,
    output logic [`MASTER_COUNT-1:0]                          eoc,
    output bus_panel_pkg::panel_status_t                      status
);

    bus_panel_pkg::panel_state_e next_state;
    logic                        step;
    logic                        no_ids;
    logic [`MASTER_COUNT-1:0]    no_slave;
    logic                        com_finished;

    assign step   = ~step_n;
    assign no_ids = (sw[`MASTER_COUNT*`SLAVE_ID_WIDTH-1:0] == '0);

    always_comb begin
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            no_slave[m] = (setup[m].slave_id == '0);
        end
    end

    // a master without a slave never reports done, so it counts as finished
    assign com_finished = &(done | no_slave);

    always_comb begin
        next_state = state;
        case (state)
            bus_panel_pkg::pick_slave: begin
                if (step) begin
                    next_state = no_ids ? bus_panel_pkg::com_done : bus_panel_pkg::pick_rw;
                end
            end
            bus_panel_pkg::pick_rw: begin
                if (step) next_state = bus_panel_pkg::pick_ext;
            end
            bus_panel_pkg::pick_ext: begin
                if (step) begin
                    case (sw[1:0])
                        2'b01:   next_state = bus_panel_pkg::ext_write_m0;
                        2'b10:   next_state = bus_panel_pkg::ext_write_m1;
                        2'b11:   next_state = bus_panel_pkg::ext_write_both;
                        default: next_state = bus_panel_pkg::first_addr_m0;
                    endcase
                end
            end
            bus_panel_pkg::ext_write_m0,
            bus_panel_pkg::ext_write_m1: begin
                if (step) next_state = bus_panel_pkg::first_addr_m0;
            end
            bus_panel_pkg::ext_write_both: begin
                if (step) next_state = bus_panel_pkg::ext_write_m1;
            end
            bus_panel_pkg::first_addr_m0: begin
                if (step) next_state = bus_panel_pkg::first_addr_m1;
            end
            bus_panel_pkg::first_addr_m1: begin
                if (step) next_state = bus_panel_pkg::count_m0;
            end
            bus_panel_pkg::count_m0: begin
                if (step) next_state = bus_panel_pkg::count_m1;
            end
            bus_panel_pkg::count_m1: begin
                if (step) next_state = bus_panel_pkg::configure;
            end
            bus_panel_pkg::configure: begin
                if (config_done) next_state = bus_panel_pkg::com_ready;
            end
            bus_panel_pkg::com_ready: begin
                if (step) next_state = bus_panel_pkg::communicating;
            end
            bus_panel_pkg::communicating: begin
                if (com_finished) next_state = bus_panel_pkg::com_done;
            end
            bus_panel_pkg::com_done: next_state = bus_panel_pkg::com_done;   // held until reset
            default: next_state = bus_panel_pkg::pick_slave;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= bus_panel_pkg::pick_slave;
            setup <= '0;
            eoc   <= '0;
        end else begin
            state <= next_state;
            if (step) begin
                for (int m = 0; m < `MASTER_COUNT; m++) begin
                    case (state)
                        bus_panel_pkg::pick_slave:
                            setup[m].slave_id <= sw[m*`SLAVE_ID_WIDTH +: `SLAVE_ID_WIDTH];
                        bus_panel_pkg::pick_rw:  setup[m].rd_wr <= sw[m];
                        bus_panel_pkg::pick_ext: setup[m].in_ex <= sw[m];
                        default: ;
                    endcase
                end
            end
            // nothing selected, masters skip straight to their end state
            if (state == bus_panel_pkg::pick_slave && step && no_ids) begin
                eoc <= '1;
            end
        end
    end

    assign status.idle  = (state == bus_panel_pkg::pick_slave);
    assign status.ready = (state == bus_panel_pkg::com_ready);
    assign status.busy  = (state == bus_panel_pkg::communicating);
    assign status.done  = (state == bus_panel_pkg::com_done);

endmodule

// File: hw/write_bank.sv
`timescale 1ns/1ps
`include "bus_panel_config.svh"

module write_bank (
    input  logic                                            clk,
    input  logic                                            rstN,
    input  bus_panel_pkg::panel_state_e                     state,
    input  logic                                            next_addr_n,
    input  logic                                            step_n,
    input  logic [`DATA_WIDTH-1:0]                          sw_data,
    input  logic                                            rd_master,
    input  logic [$clog2(`BANK_DEPTH)-1:0]                  rd_index,
    output logic [`DATA_WIDTH-1:0]                          rd_data,
    output logic [`MASTER_COUNT-1:0][$clog2(`BANK_DEPTH):0] count,
    output logic [`MASTER_COUNT-1:0]                        burst
);

    localparam int IW = $clog2(`BANK_DEPTH);

    logic [`DATA_WIDTH-1:0] mem [`MASTER_COUNT][`BANK_DEPTH];
    logic [IW-1:0]          ptr;       // shared by both masters
    logic                   in_write;
    logic                   target;    // master being filled
    logic                   wr_en;

    assign in_write = (state == bus_panel_pkg::ext_write_m0)
                   || (state == bus_panel_pkg::ext_write_m1)
                   || (state == bus_panel_pkg::ext_write_both);
    assign target   = (state == bus_panel_pkg::ext_write_m1);

    // step wins over a simultaneous next press, a full bank ignores presses
    assign wr_en = in_write && step_n && !next_addr_n && (count[target] < `BANK_DEPTH);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ptr   <= '0;
            count <= '0;
            burst <= '0;
        end else if (in_write && !step_n) begin
            ptr <= '0;   // next master starts at the bottom
        end else if (wr_en) begin
            ptr           <= ptr + 1'b1;
            count[target] <= count[target] + 1'b1;
            burst[target] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[target][ptr] <= sw_data;
    end

    assign rd_data = mem[rd_master][rd_index];

endmodule

// File: hw/addr_range.sv
`timescale 1ns/1ps
`include "bus_panel_config.svh"

module addr_range (
    input  logic                                              clk,
    input  logic                                              rstN,
    input  bus_panel_pkg::panel_state_e                       state,
    input  logic [`ADDR_WIDTH-1:0]                            sw_addr,
    input  bus_panel_pkg::master_setup_t [`MASTER_COUNT-1:0]  setup,
    output logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]         first_addr,
    output logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]         last_addr
);

    localparam int SUM_W = `ADDR_WIDTH + 1;   // one spare bit for the overrun

    logic [`MASTER_COUNT-1:0][SUM_W-1:0]       depth;
    logic [`MASTER_COUNT-1:0][SUM_W-1:0]       sum;
    logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0] clamped;

    always_comb begin
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            case (setup[m].slave_id)
                2'd1:    depth[m] = SUM_W'(`SLAVE1_DEPTH);
                2'd2:    depth[m] = SUM_W'(`SLAVE2_DEPTH);
                2'd3:    depth[m] = SUM_W'(`SLAVE3_DEPTH);
                default: depth[m] = SUM_W'(2 ** `ADDR_WIDTH);   // no slave, full master range
            endcase
            sum[m]     = {1'b0, first_addr[m]} + {1'b0, sw_addr};
            clamped[m] = (sum[m] >= depth[m]) ? depth[m][`ADDR_WIDTH-1:0]
                                              : sum[m][`ADDR_WIDTH-1:0];
        end
    end

    // values follow sw while in the state, so the step edge leaves the last one
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            first_addr <= '0;
            last_addr  <= '0;
        end else begin
            if (state == bus_panel_pkg::first_addr_m0) first_addr[0] <= sw_addr;
            if (state == bus_panel_pkg::first_addr_m1) first_addr[1] <= sw_addr;
            if (state == bus_panel_pkg::count_m0)      last_addr[0]  <= clamped[0];
            if (state == bus_panel_pkg::count_m1)      last_addr[1]  <= clamped[1];
        end
    end

endmodule

// File: hw/cmd_sequencer.sv
`timescale 1ns/1ps
`include "bus_panel_config.svh"

module cmd_sequencer (
    input  logic                                              clk,
    input  logic                                              rstN,
    input  bus_panel_pkg::panel_state_e                       state,
    input  logic                                              step_n,
    input  bus_panel_pkg::master_setup_t [`MASTER_COUNT-1:0]  setup,
    input  logic [`MASTER_COUNT-1:0][$clog2(`BANK_DEPTH):0]   count,
    input  logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]         first_addr,
    input  logic [`ADDR_WIDTH-1:0]                            sw_addr,
    output logic                                              rd_master,
    output logic [$clog2(`BANK_DEPTH)-1:0]                    rd_index,
    input  logic [`DATA_WIDTH-1:0]                            rd_data,
    output logic [`MASTER_COUNT-1:0]                          start,
    output logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]         address,
    output logic [`MASTER_COUNT-1:0][`DATA_WIDTH-1:0]         data,
    output logic                                              config_done
);

    localparam int IW      = $clog2(`BANK_DEPTH);
    localparam int CW      = IW + 1;
    localparam int SLOT_W  = (`SLOT_CYCLES > 1) ? $clog2(`SLOT_CYCLES) : 1;
    localparam int DELAY_W = (`START_DELAY > 0) ? $clog2(`START_DELAY + 1) : 1;
    localparam logic [`MASTER_COUNT-1:0] FIRST_MASK = `MASTER_COUNT'(1) << `FIRST_MASTER;

    bus_panel_pkg::config_step_e cstep;
    logic [SLOT_W-1:0]           slot_cnt;
    logic                        m_idx;       // master being configured
    logic [IW-1:0]               s_idx;       // slot within that master
    logic [IW-1:0]               last_slot;
    logic [CW-1:0]               n;
    logic                        slot_end;
    logic [`DATA_WIDTH-1:0]      slot_value;
    logic [DELAY_W-1:0]          delay_cnt;
    logic                        started;     // every master has had its start pulse

    assign n        = count[m_idx];
    assign slot_end = (slot_cnt == SLOT_W'(`SLOT_CYCLES - 1));

    // at least two slots, so first and last start pulses never merge
    assign last_slot = (setup[m_idx].in_ex && n > CW'(2)) ? IW'(n - CW'(1)) : IW'(1);

    assign rd_master  = m_idx;
    assign rd_index   = (CW'(s_idx) < n) ? s_idx : IW'(n - CW'(1));   // repeat the last value
    assign slot_value = (setup[m_idx].in_ex && n != '0) ? rd_data : '0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cstep       <= bus_panel_pkg::step_first;
            slot_cnt    <= '0;
            m_idx       <= 1'b0;
            s_idx       <= '0;
            config_done <= 1'b0;
        end else if (state != bus_panel_pkg::configure) begin
            cstep       <= bus_panel_pkg::step_first;
            slot_cnt    <= '0;
            m_idx       <= 1'b0;
            s_idx       <= '0;
            config_done <= 1'b0;
        end else begin
            config_done <= 1'b0;
            if (cstep != bus_panel_pkg::step_done) begin
                slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
            end
            if (slot_end) begin
                case (cstep)
                    bus_panel_pkg::step_first,
                    bus_panel_pkg::step_middle: begin
                        s_idx <= s_idx + 1'b1;
                        cstep <= (s_idx + 1'b1 == last_slot) ? bus_panel_pkg::step_last
                                                             : bus_panel_pkg::step_middle;
                    end
                    bus_panel_pkg::step_last: begin
                        s_idx <= '0;
                        if (m_idx == 1'(`MASTER_COUNT - 1)) begin
                            cstep       <= bus_panel_pkg::step_done;
                            config_done <= 1'b1;
                        end else begin
                            m_idx <= m_idx + 1'b1;
                            cstep <= bus_panel_pkg::step_first;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // command outputs lag the slot counters by one cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            start     <= '0;
            address   <= '0;
            data      <= '0;
            delay_cnt <= '0;
            started   <= 1'b0;
        end else begin
            start <= '0;
            case (state)
                bus_panel_pkg::configure: begin
                    if (cstep != bus_panel_pkg::step_done) begin
                        start[m_idx]   <= (slot_cnt == '0)
                                       && (cstep == bus_panel_pkg::step_first
                                           || cstep == bus_panel_pkg::step_last);
                        address[m_idx] <= first_addr[m_idx];
                        data[m_idx]    <= slot_value;
                    end
                end
                bus_panel_pkg::com_ready: begin
                    if (!step_n) begin
                        if (`START_DELAY == 0) begin
                            start   <= '1;   // all masters together
                            started <= 1'b1;
                        end else begin
                            start <= FIRST_MASK;
                        end
                    end
                end
                bus_panel_pkg::communicating: begin
                    if (!started) begin
                        delay_cnt <= delay_cnt + 1'b1;
                        if (delay_cnt == DELAY_W'(`START_DELAY)) begin
                            start   <= ~FIRST_MASK;
                            started <= 1'b1;
                        end
                    end
                end
                bus_panel_pkg::com_done: begin
                    for (int m = 0; m < `MASTER_COUNT; m++) begin
                        address[m] <= sw_addr;   // read-back address from the switches
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: hw/bus_panel_top.sv
`timescale 1ns/1ps
`include "bus_panel_config.svh"

module bus_panel_top (
    input  logic                                            clk,
    input  logic                                            rstN,
    input  logic [17:0]                                     sw,
    input  logic                                            step_n,
    input  logic                                            next_addr_n,
    input  logic [`MASTER_COUNT-1:0]                        done,
    output bus_panel_pkg::master_cmd_t [`MASTER_COUNT-1:0]  cmd,
    output bus_panel_pkg::panel_status_t                    status
);

    bus_panel_pkg::panel_state_e                      state;
    bus_panel_pkg::master_setup_t [`MASTER_COUNT-1:0] setup;
    logic                                             config_done;
    logic [`MASTER_COUNT-1:0]                         eoc;
    logic [`MASTER_COUNT-1:0]                         start;
    logic [`MASTER_COUNT-1:0]                         burst;
    logic [`MASTER_COUNT-1:0][$clog2(`BANK_DEPTH):0]  count;
    logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]        first_addr;
    logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]        last_addr;
    logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]        address;
    logic [`MASTER_COUNT-1:0][`DATA_WIDTH-1:0]        data;
    logic                                             rd_master;
    logic [$clog2(`BANK_DEPTH)-1:0]                   rd_index;
    logic [`DATA_WIDTH-1:0]                           rd_data;

    panel_fsm u_fsm (
        .clk, .rstN, .step_n, .sw, .config_done, .done,
        .state, .setup, .eoc, .status
    );

    write_bank u_bank (
        .clk, .rstN, .state, .next_addr_n, .step_n,
        .sw_data (sw[`DATA_WIDTH-1:0]),
        .rd_master, .rd_index, .rd_data, .count, .burst
    );

    addr_range u_range (
        .clk, .rstN, .state,
        .sw_addr (sw[`ADDR_WIDTH-1:0]),
        .setup, .first_addr, .last_addr
    );

    cmd_sequencer u_seq (
        .clk, .rstN, .state, .step_n, .setup, .count, .first_addr,
        .sw_addr (sw[`ADDR_WIDTH-1:0]),
        .rd_master, .rd_index, .rd_data, .start, .address, .data, .config_done
    );

    always_comb begin
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            cmd[m].start     = start[m];
            cmd[m].eoc       = eoc[m];
            cmd[m].burst     = burst[m];
            cmd[m].rd_wr     = setup[m].rd_wr;
            cmd[m].in_ex     = setup[m].in_ex;
            cmd[m].slave_id  = setup[m].slave_id;
            cmd[m].address   = address[m];
            cmd[m].last_addr = last_addr[m];
            cmd[m].data      = data[m];
        end
    end

endmodule

// File: testbench/bus_panel_asserts.sv
`timescale 1ns/1ps
`include "bus_panel_config.svh"

module bus_panel_asserts #(
    parameter int SW = 1
) (
    input logic                                       clk,
    input logic                                       rstN,
    input bus_panel_pkg::panel_state_e                state,
    input logic [`MASTER_COUNT-1:0]                   start,
    input logic                                       config_done,
    input logic [`MASTER_COUNT-1:0][`DATA_WIDTH-1:0]  data,
    input logic [SW-1:0]                              slot_cnt
);

    // every start is a single-cycle pulse
    start_single_cycle: assert property (@(posedge clk) disable iff (!rstN)
        (start & $past(start)) == '0)
        else $error("start held high for two cycles");

    config_done_in_configure: assert property (@(posedge clk) disable iff (!rstN)
        config_done |-> state == bus_panel_pkg::configure)
        else $error("config_done high outside configure");

    // data only moves on the first cycle of a slot
    data_stable_in_slot: assert property (@(posedge clk) disable iff (!rstN)
        (state == bus_panel_pkg::configure && slot_cnt != '0) |=> $stable(data))
        else $error("data changed within a configuration slot");

endmodule

bind cmd_sequencer bus_panel_asserts #(.SW(SLOT_W)) u_asserts (
    .clk         (clk),
    .rstN        (rstN),
    .state       (state),
    .start       (start),
    .config_done (config_done),
    .data        (data),
    .slot_cnt    (slot_cnt)
);

// File: testbench/bus_panel_tb.sv
`timescale 1ns/1ps
`include "bus_panel_config.svh"

module bus_panel_tb;

    logic                                           clk;
    logic                                           rstN;
    logic [17:0]                                    sw;
    logic                                           step_n;
    logic                                           next_addr_n;
    logic [`MASTER_COUNT-1:0]                       done;
    bus_panel_pkg::master_cmd_t [`MASTER_COUNT-1:0] cmd;
    bus_panel_pkg::panel_status_t                   status;

    logic [`DATA_WIDTH-1:0] bank [`MASTER_COUNT][`BANK_DEPTH];   // values the masters should see
    int test_errors;
    int tests_run;
    int tests_failed;

    bus_panel_top DUT (
        .clk, .rstN, .sw, .step_n, .next_addr_n, .done, .cmd, .status
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int expected_slot_count(input int n, input logic in_ex);
        if (in_ex && n > 2) return n;
        return 2;
    endfunction

    function automatic logic [15:0] expected_slot_data(input int m, input int i, input int n,
                                                       input logic in_ex);
        if (!in_ex || n == 0) return '0;
        return bank[m][(i < n) ? i : n - 1];   // last value repeats
    endfunction

    function automatic logic [11:0] expected_last_addr(input logic [11:0] first,
                                                       input logic [11:0] cnt,
                                                       input logic [1:0] id);
        int depth;
        int sum;
        case (id)
            2'd1:    depth = `SLAVE1_DEPTH;
            2'd2:    depth = `SLAVE2_DEPTH;
            2'd3:    depth = `SLAVE3_DEPTH;
            default: depth = 4096;
        endcase
        sum = int'(first) + int'(cnt);
        if (sum >= depth) return 12'(depth);   // depth wraps in the 12-bit field
        return 12'(sum);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %s: FAIL (%0d errors)", name, test_errors);
        end else begin
            $display("test %s: ok", name);
        end
        test_errors = 0;
    endtask

    task automatic reset_dut();
        rstN        <= 1'b0;
        sw          <= '0;
        step_n      <= 1'b1;
        next_addr_n <= 1'b1;
        done        <= '0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    endtask

    task automatic press_step(input logic [17:0] value);
        @(posedge clk);
        sw     <= value;
        step_n <= 1'b0;
        @(posedge clk);
        step_n <= 1'b1;
    endtask

    task automatic fill_bank(input int m, input int n);
        logic [15:0] v;
        for (int i = 0; i < n; i++) begin
            v = 16'($urandom);
            bank[m][i] = v;
            @(posedge clk);
            sw          <= 18'(v);
            next_addr_n <= 1'b0;
            @(posedge clk);
            next_addr_n <= 1'b1;
        end
    endtask

    task automatic run_round(input string name, input logic [1:0] ext, input int n0,
                             input int n1, input logic [1:0] id0, input logic [1:0] id1);
        logic [1:0]  rw;
        logic [11:0] first [2];
        logic [11:0] cnt [2];
        logic [1:0]  id [2];
        int          n [2];
        int          slots [2];
        int          dly [2];
        int          m;
        int          k;
        int          dmax;
        int          wait_cnt;
        logic [11:0] rd_addr;
        id[0] = id0;
        id[1] = id1;
        n[0]  = n0;
        n[1]  = n1;
        rw    = 2'($urandom);
        @(posedge clk);
        reset_dut();
        press_step(18'({id1, id0}));
        press_step(18'(rw));
        press_step(18'(ext));
        if (ext == 2'b11) begin
            fill_bank(0, n0);
            press_step(18'd0);
            fill_bank(1, n1);
        end else if (ext == 2'b01) begin
            fill_bank(0, n0);
        end else if (ext == 2'b10) begin
            fill_bank(1, n1);
        end
        if (ext != 2'b00) press_step(18'd0);
        for (int i = 0; i < 2; i++) begin
            first[i] = 12'($urandom);
            cnt[i]   = 12'($urandom);
            slots[i] = expected_slot_count(n[i], ext[i]);
        end
        press_step(18'(first[0]));
        press_step(18'(first[1]));
        press_step(18'(cnt[0]));
        press_step(18'(cnt[1]));   // now in configure
        @(negedge clk);
        for (int i = 0; i < 2; i++) begin
            check_value($sformatf("cmd[%0d].slave_id", i), 32'(cmd[i].slave_id), 32'(id[i]));
            check_value($sformatf("cmd[%0d].rd_wr", i), 32'(cmd[i].rd_wr), 32'(rw[i]));
            check_value($sformatf("cmd[%0d].in_ex", i), 32'(cmd[i].in_ex), 32'(ext[i]));
            check_value($sformatf("cmd[%0d].burst", i), 32'(cmd[i].burst), 32'(n[i] > 0));
            check_value($sformatf("cmd[%0d].last_addr", i), 32'(cmd[i].last_addr),
                        32'(expected_last_addr(first[i], cnt[i], id[i])));
        end
        end_test({name, " setup"});
        for (int j = 0; j < 2 * (slots[0] + slots[1]); j++) begin
            @(negedge clk);
            m = (j < 2 * slots[0]) ? 0 : 1;
            k = j - ((m == 1) ? 2 * slots[0] : 0);
            check_value($sformatf("cmd[%0d].start", m), 32'(cmd[m].start),
                        32'((k % 2 == 0) && (k / 2 == 0 || k / 2 == slots[m] - 1)));
            check_value($sformatf("cmd[%0d].start", 1 - m), 32'(cmd[1 - m].start), 32'h0);
            check_value($sformatf("cmd[%0d].data", m), 32'(cmd[m].data),
                        32'(expected_slot_data(m, k / 2, n[m], ext[m])));
            check_value($sformatf("cmd[%0d].address", m), 32'(cmd[m].address), 32'(first[m]));
        end
        wait_cnt = 0;
        while (!status.ready && wait_cnt < 8) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!status.ready) report_timeout("status.ready after configure");
        end_test({name, " configure"});
        press_step(18'd0);
        @(negedge clk);
        check_value("start", 32'({cmd[1].start, cmd[0].start}), 32'h3);
        check_value("status.busy", 32'(status.busy), 32'h1);
        dmax = 0;
        for (int i = 0; i < 2; i++) begin
            dly[i] = 2 + int'($urandom % 8);
            if (id[i] != 2'd0 && dly[i] > dmax) dmax = dly[i];
        end
        wait_cnt = 0;
        while (!status.done && wait_cnt < 40) begin   // stand-in masters answer here
            @(posedge clk);
            wait_cnt++;
            for (int i = 0; i < 2; i++) begin
                if (wait_cnt == dly[i] && id[i] != 2'd0) done[i] <= 1'b1;
            end
            @(negedge clk);
            if (wait_cnt == 1) begin
                check_value("start", 32'({cmd[1].start, cmd[0].start}), 32'h0);
            end
        end
        if (!status.done) report_timeout("status.done in communicating");
        else check_value("status.done latency", 32'(wait_cnt), 32'(dmax + 1));
        rd_addr = 12'($urandom);
        @(posedge clk);
        sw <= 18'(rd_addr);
        @(posedge clk);
        @(negedge clk);
        check_value("cmd[0].address", 32'(cmd[0].address), 32'(rd_addr));
        check_value("cmd[1].address", 32'(cmd[1].address), 32'(rd_addr));
        end_test({name, " communicate"});
    endtask

    initial begin
        void'($urandom(32'h17d9));
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_dut();
        @(negedge clk);
        check_value("status", 32'(status), 32'h8);
        for (int i = 0; i < 2; i++) begin
            check_value($sformatf("cmd[%0d]", i), 32'(cmd[i] == '0), 32'h1);
        end
        end_test("reset");
        @(posedge clk);
        reset_dut();
        press_step(18'd0);   // no slave for either master
        @(negedge clk);
        check_value("status", 32'(status), 32'h1);
        check_value("eoc", 32'({cmd[1].eoc, cmd[0].eoc}), 32'h3);
        end_test("skip");
        run_round("round0", 2'b11, 0, 5, 2'd3, 2'(1 + $urandom % 3));
        run_round("round1", 2'b01, 1, 0, 2'(1 + $urandom % 3), 2'd3);
        run_round("round2", 2'b10, 0, 3, 2'd0, 2'd3);
        run_round("round3", 2'b11, 16, 2, 2'(1 + $urandom % 3), 2'(1 + $urandom % 3));
        run_round("round4", 2'b00, 0, 0, 2'd3, 2'd0);
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/bus_panel_pkg.sv
hw/panel_fsm.sv
hw/write_bank.sv
hw/addr_range.sv
hw/cmd_sequencer.sv
hw/bus_panel_top.sv
testbench/bus_panel_asserts.sv
testbench/bus_panel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the bus panel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module bus_panel_tb \
    --Mdir obj_dir -o sim_bus_panel > build.log 2>&1 \
    && ./obj_dir/sim_bus_panel > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }

grep -q "Simulation completed successfully" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
